// File: verilog/rv_pkg.sv
package rv_pkg;

	////////////////////////////////////////
	// Widths with a meaning
	////////////////////////////////////////
	typedef logic [11:0] pc_t;        // Instruction byte address
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [3:0]  alu_op_t;

	// Major opcodes, inst[6:0]
	localparam logic [6:0] OP_REG   = 7'b0110011;
	localparam logic [6:0] OP_IMM   = 7'b0010011;
	localparam logic [6:0] OP_LOAD  = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_LUI   = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;

	// ALU operations
	localparam alu_op_t ALU_ADD  = 4'd0;
	localparam alu_op_t ALU_SUB  = 4'd1;
	localparam alu_op_t ALU_AND  = 4'd2;
	localparam alu_op_t ALU_OR   = 4'd3;
	localparam alu_op_t ALU_XOR  = 4'd4;
	localparam alu_op_t ALU_SLT  = 4'd5;
	localparam alu_op_t ALU_SLTU = 4'd6;
	localparam alu_op_t ALU_SLL  = 4'd7;
	localparam alu_op_t ALU_SRL  = 4'd8;
	localparam alu_op_t ALU_SRA  = 4'd9;

	// Immediate formats
	localparam logic [2:0] IMM_I = 3'd0;
	localparam logic [2:0] IMM_S = 3'd1;
	localparam logic [2:0] IMM_U = 3'd2;

	// Load select, same encoding as funct3
	localparam logic [2:0] LD_B  = 3'b000;
	localparam logic [2:0] LD_H  = 3'b001;
	localparam logic [2:0] LD_W  = 3'b010;
	localparam logic [2:0] LD_BU = 3'b100;
	localparam logic [2:0] LD_HU = 3'b101;

	// Store width, funct3[1:0]
	localparam logic [1:0] ST_B = 2'd0;
	localparam logic [1:0] ST_H = 2'd1;
	localparam logic [1:0] ST_W = 2'd2;

	// Writeback source
	localparam logic [1:0] WB_PC4  = 2'd0;
	localparam logic [1:0] WB_ALU  = 2'd1;
	localparam logic [1:0] WB_IMM  = 2'd2;
	localparam logic [1:0] WB_LOAD = 2'd3;

	// Memory sizes in words
	localparam int IMEM_WORDS = 1024;               // Covers the whole 12-bit PC
	localparam int IMEM_AW    = $clog2(IMEM_WORDS);
	localparam int DMEM_WORDS = 256;
	localparam int DMEM_AW    = $clog2(DMEM_WORDS); // ALU result bits 9:2

endpackage

// File: verilog/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
	input  logic                       CLK100MHZ,
	input  logic                       reset,
	input  logic                       imem_wr_en,   // Program load strobe
	input  logic [rv_pkg::IMEM_AW-1:0] imem_addr,    // Word index
	input  rv_pkg::word_t              imem_data,
	output rv_pkg::pc_t                if_pc,
	output rv_pkg::pc_t                id_pc,
	output rv_pkg::pc_t                id_pc4,
	output rv_pkg::word_t              id_inst
);
	import rv_pkg::*;

	pc_t   pc_q;
	pc_t   if_pc4;
	word_t if_inst;
	word_t imem [IMEM_WORDS];

	// No branches yet, next PC is always PC+4
	assign if_pc4 = pc_q + 12'd4;
	assign if_pc  = pc_q;

	always_ff @(posedge CLK100MHZ) begin
		if (reset)
			pc_q <= '0;
		else
			pc_q <= if_pc4;
	end

	// Instruction memory, loaded through the write port
	always_ff @(posedge CLK100MHZ) begin
		if (imem_wr_en)
			imem[imem_addr] <= imem_data;
	end

	assign if_inst = imem[pc_q[IMEM_AW+1:2]];   // Async read at PC

	////////////////////////////////////////
	// IF/ID pipeline register
	////////////////////////////////////////
	always_ff @(posedge CLK100MHZ) begin
		if (reset) begin
			id_pc   <= '0;
			id_pc4  <= '0;
			id_inst <= '0;       // Opcode 0 decodes as a bubble
		end else begin
			id_pc   <= pc_q;
			id_pc4  <= if_pc4;
			id_inst <= if_inst;
		end
	end

	// Program must be loaded before the core starts running
	a_load_in_reset: assert property (@(posedge CLK100MHZ) !reset |-> !imem_wr_en)
		else $error("imem written while the core is running");

endmodule

// File: verilog/regfile.sv
`timescale 1ns/1ps

module regfile (
	input  logic              CLK100MHZ,
	input  logic              reset,
	input  rv_pkg::reg_addr_t src1_addr,
	input  rv_pkg::reg_addr_t src2_addr,
	input  rv_pkg::reg_addr_t dest_addr,
	input  logic              wr_en,
	input  rv_pkg::word_t     wr_data,
	output rv_pkg::word_t     src1_out,
	output rv_pkg::word_t     src2_out
);
	import rv_pkg::*;

	word_t regs [32];

	always_ff @(posedge CLK100MHZ) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[dest_addr] <= wr_data;   // x0 filtered in decode
		end
	end

	// Write-through bypass
	// Reader in ID sees the value retiring in WB this same cycle
	assign src1_out = (wr_en && dest_addr == src1_addr) ? wr_data : regs[src1_addr];
	assign src2_out = (wr_en && dest_addr == src2_addr) ? wr_data : regs[src2_addr];

	// Decoder clears wr_en for rd = x0, so x0 stays zero
	a_no_x0_write: assert property (@(posedge CLK100MHZ) disable iff (reset)
		!(wr_en && dest_addr == '0))
		else $error("write to x0 reached the register file");

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input  logic              CLK100MHZ,
	input  logic              reset,
	input  rv_pkg::pc_t       id_pc,
	input  rv_pkg::pc_t       id_pc4,
	input  rv_pkg::word_t     id_inst,
	input  logic              wb_wr_en,         // Writeback port
	input  rv_pkg::reg_addr_t wb_rd,
	input  rv_pkg::word_t     wb_wr_data,
	output rv_pkg::pc_t       exe_pc,
	output rv_pkg::pc_t       exe_pc4,
	output rv_pkg::word_t     exe_rfout_a,
	output rv_pkg::word_t     exe_rfout_b,
	output rv_pkg::word_t     exe_imm,
	output rv_pkg::reg_addr_t exe_rd,
	output rv_pkg::alu_op_t   exe_alu_op,
	output logic              exe_sel_op_a,     // 1 rs1, 0 PC
	output logic              exe_sel_op_b,     // 1 imm, 0 rs2
	output logic              exe_is_store,
	output logic              exe_wr_en,
	output logic [2:0]        exe_dm_select,
	output logic [1:0]        exe_store_select,
	output logic [1:0]        exe_sel_data
);
	import rv_pkg::*;

	// Instruction fields
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_addr_t  rs_a, rs_b, rd;

	// Control set
	alu_op_t    alu_op;
	logic       sel_op_a, sel_op_b;
	logic       is_store;
	logic       wr_en;
	logic [2:0] dm_select;
	logic [2:0] imm_select;
	logic [1:0] store_select;
	logic [1:0] sel_data;

	word_t      rfout_a, rfout_b;
	word_t      imm;

	assign opcode = id_inst[6:0];
	assign rd     = id_inst[11:7];
	assign funct3 = id_inst[14:12];
	assign rs_a   = id_inst[19:15];
	assign rs_b   = id_inst[24:20];
	assign funct7 = id_inst[31:25];

	// funct3 to ALU op; alt is funct7[5]
	function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt,
			input logic is_reg);
		case (f3)
			3'b000:  alu_sel = (is_reg && alt) ? ALU_SUB : ALU_ADD;   // No SUBI
			3'b001:  alu_sel = ALU_SLL;
			3'b010:  alu_sel = ALU_SLT;
			3'b011:  alu_sel = ALU_SLTU;
			3'b100:  alu_sel = ALU_XOR;
			3'b101:  alu_sel = alt ? ALU_SRA : ALU_SRL;
			3'b110:  alu_sel = ALU_OR;
			default: alu_sel = ALU_AND;
		endcase
	endfunction

	////////////////////////////////////////
	// Control decoder
	////////////////////////////////////////
	always_comb begin
		alu_op       = ALU_ADD;    // Address add for loads and stores
		sel_op_a     = 1'b1;
		sel_op_b     = 1'b1;
		is_store     = 1'b0;
		wr_en        = 1'b0;       // Unknown opcodes retire as bubbles
		dm_select    = LD_W;
		imm_select   = IMM_I;
		store_select = ST_W;
		sel_data     = WB_ALU;
		case (opcode)
			OP_REG: begin
				alu_op   = alu_sel(funct3, funct7[5], 1'b1);
				sel_op_b = 1'b0;
				wr_en    = 1'b1;
			end
			OP_IMM: begin
				alu_op = alu_sel(funct3, funct7[5], 1'b0);
				wr_en  = 1'b1;
			end
			OP_LOAD: begin
				dm_select = funct3;
				sel_data  = WB_LOAD;
				wr_en     = 1'b1;
			end
			OP_STORE: begin
				is_store     = 1'b1;
				imm_select   = IMM_S;
				store_select = funct3[1:0];
			end
			OP_LUI: begin
				imm_select = IMM_U;
				sel_data   = WB_IMM;   // Immediate straight to rd
				wr_en      = 1'b1;
			end
			OP_AUIPC: begin
				imm_select = IMM_U;
				sel_op_a   = 1'b0;     // PC + imm
				wr_en      = 1'b1;
			end
			default: ;
		endcase
		if (rd == '0)
			wr_en = 1'b0;          // x0 never written
	end

	// Immediate generator
	always_comb begin
		case (imm_select)
			IMM_S:   imm = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
			IMM_U:   imm = {id_inst[31:12], 12'b0};
			default: imm = {{20{id_inst[31]}}, id_inst[31:20]};
		endcase
	end

	regfile rf (
		.CLK100MHZ (CLK100MHZ),
		.reset     (reset),
		.src1_addr (rs_a),
		.src2_addr (rs_b),
		.dest_addr (wb_rd),
		.wr_en     (wb_wr_en),
		.wr_data   (wb_wr_data),
		.src1_out  (rfout_a),
		.src2_out  (rfout_b)
	);

	////////////////////////////////////////
	// ID/EXE pipeline register
	////////////////////////////////////////
	always_ff @(posedge CLK100MHZ) begin
		if (reset) begin
			exe_pc       <= '0;
			exe_pc4      <= '0;
			exe_wr_en    <= 1'b0;
			exe_is_store <= 1'b0;
		end else begin
			exe_pc       <= id_pc;
			exe_pc4      <= id_pc4;
			exe_wr_en    <= wr_en;
			exe_is_store <= is_store;
		end
	end

	// Operands and muxing controls
	always_ff @(posedge CLK100MHZ) begin
		exe_rfout_a      <= rfout_a;
		exe_rfout_b      <= rfout_b;
		exe_imm          <= imm;
		exe_rd           <= rd;
		exe_alu_op       <= alu_op;
		exe_sel_op_a     <= sel_op_a;
		exe_sel_op_b     <= sel_op_b;
		exe_dm_select    <= dm_select;
		exe_store_select <= store_select;
		exe_sel_data     <= sel_data;
	end

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
	input  logic              CLK100MHZ,
	input  logic              reset,
	input  rv_pkg::pc_t       exe_pc,
	input  rv_pkg::pc_t       exe_pc4,
	input  rv_pkg::word_t     exe_rfout_a,
	input  rv_pkg::word_t     exe_rfout_b,
	input  rv_pkg::word_t     exe_imm,
	input  rv_pkg::reg_addr_t exe_rd,
	input  rv_pkg::alu_op_t   exe_alu_op,
	input  logic              exe_sel_op_a,
	input  logic              exe_sel_op_b,
	input  logic              exe_is_store,
	input  logic              exe_wr_en,
	input  logic [2:0]        exe_dm_select,
	input  logic [1:0]        exe_store_select,
	input  logic [1:0]        exe_sel_data,
	output rv_pkg::pc_t       mem_pc4,
	output rv_pkg::pc_t       mem_pc,
	output rv_pkg::word_t     mem_alu_out,
	output rv_pkg::word_t     mem_store_data,
	output rv_pkg::word_t     mem_imm,
	output logic [3:0]        mem_dm_write,       // Byte lane mask
	output logic [2:0]        mem_dm_select,
	output logic [1:0]        mem_sel_data,
	output logic              mem_wr_en,
	output rv_pkg::reg_addr_t mem_rd
);
	import rv_pkg::*;

	word_t      op_a, op_b;
	logic [4:0] shamt;
	word_t      alu_out;
	logic [1:0] byte_off;
	word_t      store_data;
	logic [3:0] dm_write;

	// Operand select
	assign op_a  = exe_sel_op_a ? exe_rfout_a : word_t'(exe_pc);   // PC for AUIPC
	assign op_b  = exe_sel_op_b ? exe_imm : exe_rfout_b;
	assign shamt = op_b[4:0];

	////////////////////////////////////////
	// ALU
	////////////////////////////////////////
	always_comb begin
		case (exe_alu_op)
			ALU_ADD:  alu_out = op_a + op_b;
			ALU_SUB:  alu_out = op_a - op_b;
			ALU_AND:  alu_out = op_a & op_b;
			ALU_OR:   alu_out = op_a | op_b;
			ALU_XOR:  alu_out = op_a ^ op_b;
			ALU_SLT:  alu_out = word_t'($signed(op_a) < $signed(op_b));
			ALU_SLTU: alu_out = word_t'(op_a < op_b);
			ALU_SLL:  alu_out = op_a << shamt;
			ALU_SRL:  alu_out = op_a >> shamt;
			ALU_SRA:  alu_out = $signed(op_a) >>> shamt;   // Sign fill
			default:  alu_out = '0;
		endcase
	end

	// Store block, rs2 moved to its byte lane
	assign byte_off = alu_out[1:0];

	always_comb begin
		store_data = exe_rfout_b << {byte_off, 3'b000};
		case (exe_store_select)
			ST_B:    dm_write = 4'b0001 << byte_off;
			ST_H:    dm_write = byte_off[1] ? 4'b1100 : 4'b0011;
			default: dm_write = 4'b1111;
		endcase
		if (!exe_is_store)
			dm_write = 4'b0000;
	end

	////////////////////////////////////////
	// EXE/MEM pipeline register
	////////////////////////////////////////
	always_ff @(posedge CLK100MHZ) begin
		if (reset) begin
			mem_pc       <= '0;
			mem_pc4      <= '0;
			mem_dm_write <= 4'b0000;
			mem_wr_en    <= 1'b0;
		end else begin
			mem_pc       <= exe_pc;
			mem_pc4      <= exe_pc4;
			mem_dm_write <= dm_write;
			mem_wr_en    <= exe_wr_en;
		end
	end

	always_ff @(posedge CLK100MHZ) begin
		mem_alu_out    <= alu_out;
		mem_store_data <= store_data;
		mem_imm        <= exe_imm;
		mem_rd         <= exe_rd;
		mem_dm_select  <= exe_dm_select;
		mem_sel_data   <= exe_sel_data;
	end

	// Only byte, aligned half or full word masks reach the data memory
	a_dm_write_legal: assert property (@(posedge CLK100MHZ) disable iff (reset)
		$onehot0(mem_dm_write) || mem_dm_write inside {4'b0011, 4'b1100, 4'b1111})
		else $error("illegal byte mask %b", mem_dm_write);

endmodule

// File: verilog/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
	input  logic              CLK100MHZ,
	input  logic              reset,
	input  rv_pkg::pc_t       mem_pc4,
	input  rv_pkg::pc_t       mem_pc,
	input  rv_pkg::word_t     mem_alu_out,    // Data address
	input  rv_pkg::word_t     mem_store_data,
	input  rv_pkg::word_t     mem_imm,
	input  logic [3:0]        mem_dm_write,
	input  logic [2:0]        mem_dm_select,
	input  logic [1:0]        mem_sel_data,
	input  logic              mem_wr_en,
	input  rv_pkg::reg_addr_t mem_rd,
	output rv_pkg::pc_t       wb_pc,
	output logic              wb_wr_en,
	output rv_pkg::reg_addr_t wb_rd,
	output rv_pkg::word_t     wb_wr_data
);
	import rv_pkg::*;

	word_t              dmem [DMEM_WORDS];
	logic [DMEM_AW-1:0] dm_index;
	logic [1:0]         byte_off;
	word_t              dm_rdata;
	word_t              shifted;
	word_t              load_data;

	// MEM/WB payload
	pc_t                wb_pc4;
	word_t              wb_alu_out, wb_load_data, wb_imm;
	logic [1:0]         wb_sel_data;

	assign dm_index = mem_alu_out[DMEM_AW+1:2];
	assign byte_off = mem_alu_out[1:0];

	// Data memory, byte lane writes at the end of MEM
	always_ff @(posedge CLK100MHZ) begin
		for (int i = 0; i < 4; i++) begin
			if (mem_dm_write[i])
				dmem[dm_index][8*i +: 8] <= mem_store_data[8*i +: 8];
		end
	end

	assign dm_rdata = dmem[dm_index];   // Combinational read

	////////////////////////////////////////
	// Load block
	////////////////////////////////////////
	always_comb begin
		shifted = dm_rdata >> {byte_off, 3'b000};   // Addressed byte to bit 0
		case (mem_dm_select)
			LD_B:    load_data = {{24{shifted[7]}}, shifted[7:0]};
			LD_H:    load_data = {{16{shifted[15]}}, shifted[15:0]};
			LD_W:    load_data = dm_rdata;
			LD_BU:   load_data = {24'b0, shifted[7:0]};
			LD_HU:   load_data = {16'b0, shifted[15:0]};
			default: load_data = '0;
		endcase
	end

	// MEM/WB pipeline register
	always_ff @(posedge CLK100MHZ) begin
		if (reset) begin
			wb_pc    <= '0;
			wb_wr_en <= 1'b0;
		end else begin
			wb_pc    <= mem_pc;
			wb_wr_en <= mem_wr_en;
		end
	end

	always_ff @(posedge CLK100MHZ) begin
		wb_pc4       <= mem_pc4;
		wb_alu_out   <= mem_alu_out;
		wb_load_data <= load_data;
		wb_imm       <= mem_imm;
		wb_rd        <= mem_rd;
		wb_sel_data  <= mem_sel_data;
	end

	// Writeback select
	always_comb begin
		case (wb_sel_data)
			WB_PC4:  wb_wr_data = word_t'(wb_pc4);
			WB_ALU:  wb_wr_data = wb_alu_out;
			WB_IMM:  wb_wr_data = wb_imm;
			WB_LOAD: wb_wr_data = wb_load_data;
			default: wb_wr_data = '0;
		endcase
	end

	// Every store or load that retires must address the implemented words
	a_dmem_range: assert property (@(posedge CLK100MHZ) disable iff (reset)
		(|mem_dm_write || (mem_wr_en && mem_sel_data == WB_LOAD))
		|-> (mem_alu_out[31:2] < DMEM_WORDS))
		else $error("data address %h outside dmem", mem_alu_out);

endmodule

// File: verilog/rv_core.sv
`timescale 1ns/1ps

module rv_core (
	input  logic                       CLK100MHZ,
	input  logic                       reset,
	input  logic                       imem_wr_en,
	input  logic [rv_pkg::IMEM_AW-1:0] imem_addr,
	input  rv_pkg::word_t              imem_data,
	output rv_pkg::pc_t                if_pc,
	output rv_pkg::pc_t                id_pc,
	output rv_pkg::pc_t                exe_pc,
	output rv_pkg::pc_t                mem_pc,
	output rv_pkg::pc_t                wb_pc,
	output logic                       wb_wr_en,    // Writeback trace
	output rv_pkg::reg_addr_t          wb_rd,
	output rv_pkg::word_t              wb_wr_data
);
	import rv_pkg::*;

	// IF/ID
	pc_t        id_pc4;
	word_t      id_inst;

	// ID/EXE
	pc_t        exe_pc4;
	word_t      exe_rfout_a, exe_rfout_b, exe_imm;
	reg_addr_t  exe_rd;
	alu_op_t    exe_alu_op;
	logic       exe_sel_op_a, exe_sel_op_b, exe_is_store, exe_wr_en;
	logic [2:0] exe_dm_select;
	logic [1:0] exe_store_select;
	logic [1:0] exe_sel_data;

	// EXE/MEM
	pc_t        mem_pc4;
	word_t      mem_alu_out, mem_store_data, mem_imm;
	logic [3:0] mem_dm_write;
	logic [2:0] mem_dm_select;
	logic [1:0] mem_sel_data;
	logic       mem_wr_en;
	reg_addr_t  mem_rd;

	// Stages share signal names, so ports connect by name
	fetch_stage   fetch   (.*);
	decode_stage  decode  (.*);
	execute_stage execute (.*);
	mem_wb_stage  mem_wb  (.*);

endmodule

// File: tb/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
	import rv_pkg::*;

	logic        clk;
	logic        reset;
	logic        imem_wr_en;
	logic [9:0]  imem_addr;
	logic [31:0] imem_data;
	logic [11:0] if_pc, id_pc, exe_pc, mem_pc, wb_pc;
	logic        wb_wr_en;
	logic [4:0]  wb_rd;
	logic [31:0] wb_wr_data;

	// Program table, one row per instruction
	logic [31:0] prog_inst [64];
	logic        exp_wr    [64];   // Expected wb_wr_en
	logic [4:0]  exp_rd    [64];
	logic [31:0] exp_val   [64];
	logic        retired   [64];   // Row seen in WB
	int          n_rows;
	int          cycle;            // Cycles since reset fell
	int          limit;
	int          errors;
	int          checks;
	int          pad_words;        // NOPs loaded after the program

	rv_core UUT (
		.CLK100MHZ  (clk),
		.reset      (reset),
		.imem_wr_en (imem_wr_en),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.if_pc      (if_pc),
		.id_pc      (id_pc),
		.exe_pc     (exe_pc),
		.mem_pc     (mem_pc),
		.wb_pc      (wb_pc),
		.wb_wr_en   (wb_wr_en),
		.wb_rd      (wb_rd),
		.wb_wr_data (wb_wr_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;   // 100 MHz
	end

	////////////////////////////////////////
	// RV32I encoders
	////////////////////////////////////////
	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		r_type = {f7, rs2, rs1, f3, rd, OP_REG};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		i_type = {imm, rs1, f3, rd, op};   // Also loads
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		s_type = {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] op);
		u_type = {imm, rd, op};
	endfunction

	task automatic add_row(input logic [31:0] inst, input logic wr, input logic [4:0] rd,
			input logic [31:0] val);
		prog_inst[n_rows] = inst;
		exp_wr[n_rows]    = wr;
		exp_rd[n_rows]    = rd;
		exp_val[n_rows]   = val;
		retired[n_rows]   = 1'b0;
		n_rows++;
	endtask

	task automatic add_nop();
		add_row(i_type(12'h000, 0, 3'b000, 0, OP_IMM), 1'b0, 0, 0);   // ADDI x0, x0, 0
	endtask

	// Producers and readers spaced by at least two instructions
	task automatic build_program();
		n_rows = 0;
		add_row(i_type(12'h005, 0, 3'b000, 1, OP_IMM), 1'b1, 1, 32'h00000005);  // x1 = 5
		add_row(i_type(12'hFFD, 0, 3'b000, 2, OP_IMM), 1'b1, 2, 32'hFFFFFFFD);  // x2 = -3
		add_row(u_type(20'h80000, 3, OP_LUI), 1'b1, 3, 32'h80000000);
		add_nop();
		add_row(r_type(7'h00, 2, 1, 3'b000, 4), 1'b1, 4, 32'h00000002);         // ADD
		add_row(r_type(7'h20, 2, 1, 3'b000, 5), 1'b1, 5, 32'h00000008);         // SUB
		add_row(r_type(7'h00, 1, 2, 3'b010, 6), 1'b1, 6, 32'h00000001);         // SLT -3 < 5
		add_row(r_type(7'h00, 1, 2, 3'b011, 7), 1'b1, 7, 32'h00000000);         // SLTU
		add_row(r_type(7'h20, 1, 3, 3'b101, 8), 1'b1, 8, 32'hFC000000);         // SRA
		add_row(r_type(7'h00, 1, 3, 3'b101, 9), 1'b1, 9, 32'h04000000);         // SRL
		add_row(r_type(7'h00, 1, 1, 3'b001, 10), 1'b1, 10, 32'h000000A0);       // SLL
		add_row(r_type(7'h00, 1, 2, 3'b111, 11), 1'b1, 11, 32'h00000005);       // AND
		add_row(r_type(7'h00, 1, 2, 3'b110, 12), 1'b1, 12, 32'hFFFFFFFD);       // OR
		add_row(r_type(7'h00, 1, 2, 3'b100, 13), 1'b1, 13, 32'hFFFFFFF8);       // XOR
		add_row(i_type(12'h0F0, 2, 3'b111, 14, OP_IMM), 1'b1, 14, 32'h000000F0);  // ANDI
		add_row(i_type(12'hF00, 1, 3'b110, 15, OP_IMM), 1'b1, 15, 32'hFFFFFF05);  // ORI
		add_row(i_type(12'hFFF, 1, 3'b100, 16, OP_IMM), 1'b1, 16, 32'hFFFFFFFA);  // XORI -1
		add_row(i_type(12'hFFE, 2, 3'b010, 17, OP_IMM), 1'b1, 17, 32'h00000001);  // SLTI
		add_row(i_type(12'hFFF, 1, 3'b011, 18, OP_IMM), 1'b1, 18, 32'h00000001);  // SLTIU
		add_row(i_type(12'h004, 2, 3'b001, 19, OP_IMM), 1'b1, 19, 32'hFFFFFFD0);  // SLLI 4
		add_row(i_type(12'h01C, 2, 3'b101, 20, OP_IMM), 1'b1, 20, 32'h0000000F);  // SRLI 28
		add_row(i_type(12'h401, 2, 3'b101, 21, OP_IMM), 1'b1, 21, 32'hFFFFFFFE);  // SRAI 1
		add_row(u_type(20'h12345, 22, OP_AUIPC), 1'b1, 22, 32'h12345058);       // PC 0x58
		add_row(u_type(20'h87654, 23, OP_LUI), 1'b1, 23, 32'h87654000);
		add_row(i_type(12'h007, 1, 3'b000, 0, OP_IMM), 1'b0, 0, 0);             // Write to x0
		add_nop();
		add_row(i_type(12'h321, 23, 3'b000, 24, OP_IMM), 1'b1, 24, 32'h87654321); // Write-through
		add_row(r_type(7'h00, 1, 0, 3'b000, 25), 1'b1, 25, 32'h00000005);       // x0 still 0
		add_nop();
		// Stores, no writeback
		add_row(s_type(12'h000, 24, 0, 3'b010), 1'b0, 0, 0);   // SW  [0]
		add_row(s_type(12'h005, 1, 0, 3'b000), 1'b0, 0, 0);    // SB  [5]
		add_row(s_type(12'h00A, 2, 0, 3'b001), 1'b0, 0, 0);    // SH  [10]
		add_row(s_type(12'h003, 24, 0, 3'b000), 1'b0, 0, 0);   // SB  [3], word 0 = 21654321
		add_row(s_type(12'h00C, 2, 0, 3'b010), 1'b0, 0, 0);    // SW  [12]
		add_row(s_type(12'h00E, 1, 0, 3'b000), 1'b0, 0, 0);    // SB  [14], word 3 = FF05FFFD
		add_row(i_type(12'h000, 0, 3'b010, 26, OP_LOAD), 1'b1, 26, 32'h21654321);  // LW
		add_row(i_type(12'h00C, 0, 3'b000, 27, OP_LOAD), 1'b1, 27, 32'hFFFFFFFD);  // LB
		add_row(i_type(12'h00C, 0, 3'b100, 28, OP_LOAD), 1'b1, 28, 32'h000000FD);  // LBU
		add_row(i_type(12'h00E, 0, 3'b001, 29, OP_LOAD), 1'b1, 29, 32'hFFFFFF05);  // LH
		add_row(i_type(12'h00E, 0, 3'b101, 30, OP_LOAD), 1'b1, 30, 32'h0000FF05);  // LHU
		add_row(i_type(12'h002, 0, 3'b001, 31, OP_LOAD), 1'b1, 31, 32'h00002165);
		add_row(i_type(12'h005, 0, 3'b100, 26, OP_LOAD), 1'b1, 26, 32'h00000005);
		add_row(i_type(12'h00A, 0, 3'b001, 27, OP_LOAD), 1'b1, 27, 32'hFFFFFFFD);
		add_row(i_type(12'h00C, 0, 3'b010, 28, OP_LOAD), 1'b1, 28, 32'hFF05FFFD);
		add_row(r_type(7'h00, 1, 26, 3'b000, 29), 1'b1, 29, 32'h0000000A);      // Load result bypass
		add_nop();
	endtask

	// PC of a stage d cycles behind IF, 0 while the bubble from reset is there
	function automatic logic [11:0] stage_pc(input int c, input int d);
		logic [31:0] v;
		v = (c >= d) ? 32'((c - d) * 4) : 32'd0;
		stage_pc = v[11:0];
	endfunction

	task automatic expect_pc(input string name, input logic [11:0] got, input logic [11:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED cycle %0d %s: got %h expected %h", cycle, name, got, exp);
		end
	endtask

	////////////////////////////////////////
	// Per-cycle trace check
	////////////////////////////////////////
	task automatic check_cycle();
		int idx;
		expect_pc("if_pc", if_pc, stage_pc(cycle, 0));
		expect_pc("id_pc", id_pc, stage_pc(cycle, 1));
		expect_pc("exe_pc", exe_pc, stage_pc(cycle, 2));
		expect_pc("mem_pc", mem_pc, stage_pc(cycle, 3));
		expect_pc("wb_pc", wb_pc, stage_pc(cycle, 4));
		if (cycle < 4) begin
			checks++;   // Still bubbles in WB
			if (wb_wr_en !== 1'b0) begin
				errors++;
				$display("CHECK FAILED cycle %0d wb_wr_en: got %h expected %h", cycle, wb_wr_en, 1'b0);
			end
		end else begin
			idx = int'(wb_pc[11:2]);
			if (idx < n_rows) begin
				retired[idx] = 1'b1;
				checks++;
				if (wb_wr_en !== exp_wr[idx]) begin
					errors++;
					$display("CHECK FAILED row %0d wb_wr_en: got %h expected %h",
						idx, wb_wr_en, exp_wr[idx]);
				end else if (exp_wr[idx]) begin
					checks += 2;
					if (wb_rd !== exp_rd[idx]) begin
						errors++;
						$display("CHECK FAILED row %0d wb_rd: got %h expected %h",
							idx, wb_rd, exp_rd[idx]);
					end
					if (wb_wr_data !== exp_val[idx]) begin
						errors++;
						$display("CHECK FAILED row %0d wb_wr_data: got %h expected %h",
							idx, wb_wr_data, exp_val[idx]);
					end
				end
			end else if (wb_wr_en !== 1'b0) begin
				errors++;   // Padding NOPs must not write
				$display("A register write retired past the end of the program at pc %h", wb_pc);
			end
		end
	endtask

	function automatic int count_retired();
		int n;
		n = 0;
		for (int i = 0; i < n_rows; i++)
			if (retired[i])
				n++;
		count_retired = n;
	endfunction

	////////////////////////////////////////
	// Load, reset, run
	////////////////////////////////////////
	initial begin
		reset      = 1'b1;
		imem_wr_en = 1'b0;
		imem_addr  = '0;
		imem_data  = '0;
		errors     = 0;
		checks     = 0;
		cycle      = 0;
		pad_words  = 24;
		build_program();
		limit = n_rows + 20;

		// Program plus trailing NOPs, written while reset is high
		for (int i = 0; i < n_rows + pad_words; i++) begin
			@(posedge clk);
			#1;
			imem_wr_en = 1'b1;
			imem_addr  = i[9:0];
			imem_data  = (i < n_rows) ? prog_inst[i] : i_type(12'h000, 0, 3'b000, 0, OP_IMM);
		end
		@(posedge clk);
		#1 imem_wr_en = 1'b0;

		repeat (4) begin   // Reset hold after the load
			@(negedge clk);
			checks++;
			if (wb_wr_en !== 1'b0) begin
				errors++;
				$display("CHECK FAILED in reset wb_wr_en: got %h expected %h", wb_wr_en, 1'b0);
			end
			@(posedge clk);
		end
		#1 reset = 1'b0;

		// Outputs sampled mid-cycle
		while (count_retired() < n_rows && cycle < limit) begin
			@(negedge clk);
			check_cycle();
			cycle++;
		end

		if (count_retired() < n_rows) begin
			$display("Timeout after %0d cycles with instructions still in flight", cycle);
			for (int i = 0; i < n_rows; i++) begin
				if (!retired[i]) begin
					errors++;
					$display("Row %0d at pc %h never reached writeback", i, 32'(i * 4));
				end
			end
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: tb.f
verilog/rv_pkg.sv
verilog/fetch_stage.sv
verilog/regfile.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/rv_core.sv
tb/tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_rv_core -f tb.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
	exit 0
fi
echo "Pass message not found"
exit 1
